//--- hw/sme_char_pkg.sv
`default_nettype none

`include "sme_params.svh"

package sme_char_pkg;

    typedef logic [`SME_CHAR_WIDTH-1:0]  char_t;
    typedef logic [`SME_INDEX_WIDTH-1:0] str_idx_t;
    typedef logic [`SME_PLEN_WIDTH-1:0]  pat_len_t;

    // characters with a meaning in patterns and strings
    typedef enum logic [`SME_CHAR_WIDTH-1:0] {
        CH_DOT    = `SME_CH_DOT,
        CH_HAT    = `SME_CH_HAT,
        CH_DOLLAR = `SME_CH_DOLLAR,
        CH_SPACE  = `SME_CH_SPACE
    } special_char_e;

endpackage

`default_nettype wire

//--- hw/sme_ctrl_pkg.sv
`default_nettype none

package sme_ctrl_pkg;

    // load and scan phases
    typedef enum logic [1:0] {
        SEQ_IDLE    = 2'd0,
        SEQ_STRING  = 2'd1,
        SEQ_PATTERN = 2'd2,
        SEQ_SCAN    = 2'd3
    } seq_state_e;

endpackage

`default_nettype wire

//--- hw/sme_match_scanner.sv
`timescale 1ns/1ps
`default_nettype none

`include "sme_params.svh"

module sme_match_scanner
    import sme_char_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     scan_start,
    input  char_t    string_chars [`SME_STRING_MAX],
    input  str_idx_t string_len,
    input  char_t    body_chars [`SME_PATTERN_MAX],
    input  pat_len_t body_len,
    input  logic     head_anchor,
    input  logic     tail_anchor,
    output logic     scan_done,
    output logic     valid,
    output logic     match,
    output str_idx_t match_index
);

    logic                        busy;
    str_idx_t                    align;
    str_idx_t                    body_span;
    str_idx_t                    end_pos;
    str_idx_t                    prev_pos;
    logic                        fits;
    logic                        last_align;
    logic [`SME_PATTERN_MAX-1:0] char_ok;
    logic                        head_ok;
    logic                        tail_ok;
    logic                        hit;
    logic                        finish;

    assign body_span  = str_idx_t'(body_len);
    assign end_pos    = align + body_span;
    assign prev_pos   = align - 1'b1;
    assign fits       = (body_span <= string_len);
    assign last_align = (align == (string_len - body_span));

    // window compare, slots past the body always pass
    always_comb
    begin
        str_idx_t pos;
        for (int k = 0; k < `SME_PATTERN_MAX; k++)
        begin
            pos        = align + str_idx_t'(k);
            char_ok[k] = (pat_len_t'(k) >= body_len) ||
                         (body_chars[k] == CH_DOT) ||
                         (body_chars[k] == string_chars[pos[`SME_INDEX_WIDTH-2:0]]);
        end
    end

    // anchors look at the neighbors just outside the window
    assign head_ok = !head_anchor || (align == '0) ||
                     (string_chars[prev_pos[`SME_INDEX_WIDTH-2:0]] == CH_SPACE);
    assign tail_ok = !tail_anchor || (end_pos == string_len) ||
                     (string_chars[end_pos[`SME_INDEX_WIDTH-2:0]] == CH_SPACE);

    assign hit    = busy && fits && (&char_ok) && head_ok && tail_ok;
    // body longer than the string ends on the first busy cycle
    assign finish = busy && (hit || !fits || last_align);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            busy        <= 1'b0;
            align       <= '0;
            valid       <= 1'b0;
            match       <= 1'b0;
            match_index <= '0;
        end
        else
        begin
            valid <= finish;
            if (scan_start)
            begin
                busy  <= 1'b1;
                align <= '0;
            end
            else if (finish)
            begin
                busy        <= 1'b0;
                match       <= hit;
                match_index <= hit ? align : '0;
            end
            else if (busy)
            begin
                align <= align + 1'b1;
            end
        end
    end

    assign scan_done = valid;

endmodule

`default_nettype wire

//--- hw/sme_params.svh
`ifndef SME_PARAMS_SVH
`define SME_PARAMS_SVH

// character and capacity sizes
`define SME_CHAR_WIDTH   8
`define SME_STRING_MAX   32
`define SME_PATTERN_MAX  8

// 6 bits so a full string length of 32 fits
`define SME_INDEX_WIDTH  6
`define SME_PLEN_WIDTH   4

// pattern and separator codes
`define SME_CH_DOT       8'h2E
`define SME_CH_HAT       8'h5E
`define SME_CH_DOLLAR    8'h24
`define SME_CH_SPACE     8'h5F

`endif

//--- hw/sme_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sme_sequencer
    import sme_ctrl_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic isstring,
    input  logic ispattern,
    input  logic scan_done,
    output logic string_clear,
    output logic string_wr,
    output logic pattern_clear,
    output logic pattern_wr,
    output logic scan_start
);

    seq_state_e state;
    seq_state_e state_next;
    logic       string_open;

    // strings only load between scans and outside a pattern
    assign string_open   = (state == SEQ_IDLE) || (state == SEQ_STRING);
    assign string_wr     = isstring && string_open;
    assign string_clear  = string_wr && (state != SEQ_STRING);
    assign pattern_wr    = ispattern && !string_wr && (state != SEQ_SCAN);
    assign pattern_clear = pattern_wr && (state != SEQ_PATTERN);

    // falling edge of ispattern
    assign scan_start    = (state == SEQ_PATTERN) && !ispattern;

    always_comb
    begin
        state_next = state;
        case (state)
            SEQ_IDLE, SEQ_STRING:
            begin
                if (isstring)
                    state_next = SEQ_STRING;
                else if (ispattern)
                    state_next = SEQ_PATTERN;
                else
                    state_next = SEQ_IDLE;
            end
            SEQ_PATTERN:
            begin
                if (!ispattern)
                    state_next = SEQ_SCAN;
            end
            SEQ_SCAN:
            begin
                if (scan_done)
                    state_next = SEQ_IDLE;
            end
            default:
            begin
                state_next = SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= SEQ_IDLE;
        else
            state <= state_next;
    end

endmodule

`default_nettype wire

//--- hw/sme_text_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "sme_params.svh"

module sme_text_store
    import sme_char_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  char_t    chardata,
    input  logic     string_clear,
    input  logic     string_wr,
    input  logic     pattern_clear,
    input  logic     pattern_wr,
    output char_t    string_chars [`SME_STRING_MAX],
    output str_idx_t string_len,
    output char_t    body_chars [`SME_PATTERN_MAX],
    output pat_len_t body_len,
    output logic     head_anchor,
    output logic     tail_anchor
);

    str_idx_t str_wr_idx;
    logic     str_accept;
    pat_len_t body_count;
    pat_len_t pat_base;
    logic     hat_base;
    logic     pat_accept;
    logic     lead_hat;
    logic     dollar_pending;

    // string_len doubles as the write counter
    assign str_wr_idx = string_clear ? '0 : string_len;
    assign str_accept = string_wr && (str_wr_idx < str_idx_t'(`SME_STRING_MAX));

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            string_len <= '0;
        else if (string_clear || string_wr)
            string_len <= str_wr_idx + str_idx_t'(str_accept);
    end

    // whole string wiped so a shorter one leaves no old tail
    always_ff @(posedge clk)
    begin
        if (string_clear)
        begin
            for (int i = 0; i < `SME_STRING_MAX; i++)
                string_chars[i] <= '0;
        end
        if (str_accept)
            string_chars[str_wr_idx[`SME_INDEX_WIDTH-2:0]] <= chardata;
    end

    // a stripped leading hat still takes one of the pattern slots
    assign pat_base   = pattern_clear ? '0 : body_count;
    assign hat_base   = pattern_clear ? 1'b0 : head_anchor;
    assign pat_accept = pattern_wr &&
                        ((pat_base + pat_len_t'(hat_base)) < pat_len_t'(`SME_PATTERN_MAX));
    assign lead_hat   = pattern_clear && (chardata == CH_HAT);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            body_count     <= '0;
            head_anchor    <= 1'b0;
            dollar_pending <= 1'b0;
        end
        else if (pattern_clear || pat_accept)
        begin
            body_count     <= pat_base;
            head_anchor    <= hat_base | (pat_accept && lead_hat);
            dollar_pending <= 1'b0;
            if (pat_accept && !lead_hat)
            begin
                body_count     <= pat_base + 1'b1;
                dollar_pending <= (chardata == CH_DOLLAR);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (pat_accept && !lead_hat)
            body_chars[pat_base[`SME_PLEN_WIDTH-2:0]] <= chardata;
    end

    // only a final dollar is an anchor
    assign tail_anchor = dollar_pending;
    assign body_len    = body_count - pat_len_t'(dollar_pending);

endmodule

`default_nettype wire

//--- hw/string_match_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "sme_params.svh"

module string_match_engine
    import sme_char_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  char_t    chardata,
    input  logic     isstring,
    input  logic     ispattern,
    output logic     valid,
    output logic     match,
    output str_idx_t match_index
);

    logic     string_clear;
    logic     string_wr;
    logic     pattern_clear;
    logic     pattern_wr;
    logic     scan_start;
    logic     scan_done;
    char_t    string_chars [`SME_STRING_MAX];
    str_idx_t string_len;
    char_t    body_chars [`SME_PATTERN_MAX];
    pat_len_t body_len;
    logic     head_anchor;
    logic     tail_anchor;

    sme_sequencer u_sequencer (
        .clk           (clk),
        .reset         (reset),
        .isstring      (isstring),
        .ispattern     (ispattern),
        .scan_done     (scan_done),
        .string_clear  (string_clear),
        .string_wr     (string_wr),
        .pattern_clear (pattern_clear),
        .pattern_wr    (pattern_wr),
        .scan_start    (scan_start)
    );

    sme_text_store u_text_store (
        .clk           (clk),
        .reset         (reset),
        .chardata      (chardata),
        .string_clear  (string_clear),
        .string_wr     (string_wr),
        .pattern_clear (pattern_clear),
        .pattern_wr    (pattern_wr),
        .string_chars  (string_chars),
        .string_len    (string_len),
        .body_chars    (body_chars),
        .body_len      (body_len),
        .head_anchor   (head_anchor),
        .tail_anchor   (tail_anchor)
    );

    sme_match_scanner u_match_scanner (
        .clk           (clk),
        .reset         (reset),
        .scan_start    (scan_start),
        .string_chars  (string_chars),
        .string_len    (string_len),
        .body_chars    (body_chars),
        .body_len      (body_len),
        .head_anchor   (head_anchor),
        .tail_anchor   (tail_anchor),
        .scan_done     (scan_done),
        .valid         (valid),
        .match         (match),
        .match_index   (match_index)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build with Verilator and run; pass only if the testbench prints its pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module string_match_engine_tb -f string_match_engine.f -Mdir obj_dir &&
./obj_dir/Vstring_match_engine_tb | tee /dev/stderr | grep -qxF '** PASS **' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- string_match_engine.f
+incdir+hw
hw/sme_char_pkg.sv
hw/sme_ctrl_pkg.sv
hw/sme_sequencer.sv
hw/sme_text_store.sv
hw/sme_match_scanner.sv
hw/string_match_engine.sv
testbench/sme_properties.sv
testbench/string_match_engine_tb.sv

//--- testbench/sme_patterns.txt
# S <string length> <string characters in hex>
# P <pattern length> <pattern characters in hex> <test name> <expected match> <expected index>
S 11 6361745f6261745f636174
P 3 626174 literal_mid 1 4
P 2 6174 first_of_many 1 1
P 3 742e62 dot_on_space 1 2
P 3 2e2e61 dot_any 1 3
P 3 646f67 no_match 0 0
P 3 5e6174 hat_not_mid 0 0
P 4 5e626174 hat_after_space 1 4
P 4 5e636174 hat_at_start 1 0
P 4 63617424 dollar_before_space 1 0
P 5 5e2e612e24 both_anchors 1 0
S 3 736174
P 3 617424 dollar_at_end 1 1
P 2 5f63 old_tail_gone 0 0
P 4 7361745f body_too_long 0 0
P 1 73 single_char 1 0
P 2 6174 same_string_again 1 1

//--- testbench/sme_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "sme_params.svh"

module sme_properties
    import sme_char_pkg::*;
    import sme_ctrl_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input logic     isstring,
    input logic     ispattern,
    input logic     scan_start,
    input logic     valid,
    input logic     match,
    input str_idx_t match_index
);

    assert property (@(posedge clk) disable iff (reset) valid |=> !valid)
        else $error("valid stayed high for more than one cycle");

    assert property (@(posedge clk) disable iff (reset) valid |-> (!isstring && !ispattern))
        else $error("valid high while a string or pattern is loading");

    // worst case is a full string with a one character body
    assert property (@(posedge clk) disable iff (reset) scan_start |-> ##[1:34] valid)
        else $error("no valid within 34 cycles of scan start");

    assert property (@(posedge clk) disable iff (reset)
                     (valid && match) |-> (match_index < `SME_STRING_MAX))
        else $error("match index outside the string");

endmodule

bind string_match_engine sme_properties u_properties (
    .clk         (clk),
    .reset       (reset),
    .isstring    (isstring),
    .ispattern   (ispattern),
    .scan_start  (scan_start),
    .valid       (valid),
    .match       (match),
    .match_index (match_index)
);

`default_nettype wire

//--- testbench/string_match_engine_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sme_params.svh"

module string_match_engine_tb
    import sme_char_pkg::*;
;

    logic     clk;
    logic     reset;
    char_t    chardata;
    logic     isstring;
    logic     ispattern;
    logic     valid;
    logic     match;
    str_idx_t match_index;

    logic [15:0] lfsr;

    string_match_engine UUT (
        .clk         (clk),
        .reset       (reset),
        .chardata    (chardata),
        .isstring    (isstring),
        .ispattern   (ispattern),
        .valid       (valid),
        .match       (match),
        .match_index (match_index)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++)
        begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsr_step(lfsr);
        end
    endtask

    // packed file token to text, null bytes dropped
    function automatic string text_of(input logic [255:0] v);
        string s;
        s = "";
        for (int i = 31; i >= 0; i--)
        begin
            if (v[8*i +: 8] != 8'h00)
                s = $sformatf("%s%c", s, v[8*i +: 8]);
        end
        return s;
    endfunction

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic idle_gap();
        int n;
        take_bits(2, n);
        repeat (n) @(posedge clk);
    endtask

    // first character sits in the top byte of data
    task automatic send_chars(input int len, input logic [255:0] data, input logic to_pattern);
        for (int i = 0; i < len; i++)
        begin
            @(posedge clk);
            chardata  <= data[8*(len-1-i) +: 8];
            isstring  <= !to_pattern;
            ispattern <= to_pattern;
        end
        @(posedge clk);
        chardata  <= '0;
        isstring  <= 1'b0;
        ispattern <= 1'b0;
    endtask

    task automatic wait_for_valid(input string test_name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!valid && cycles < 100)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!valid)
            stop_on_error($sformatf("timeout: no valid within 100 cycles in test %s", test_name));
    endtask

    task automatic check_result(input string test_name, input string when_txt,
                                input int exp_match, input int exp_index);
        assert (match === exp_match[0])
        else
            stop_on_error($sformatf("ERR %s (%s): match expected %0d actual %0d",
                                    test_name, when_txt, exp_match, match));
        assert (match_index === exp_index[`SME_INDEX_WIDTH-1:0])
        else
            stop_on_error($sformatf("ERR %s (%s): match_index expected %0d actual %0d",
                                    test_name, when_txt, exp_index, match_index));
    endtask

    initial
    begin
        int           fd;
        int           code;
        int           len;
        int           exp_match;
        int           exp_index;
        int           pattern_count;
        logic [63:0]  tag;
        logic [255:0] data;
        logic [255:0] name_raw;
        logic [1023:0] rest;
        string        test_name;

        reset         = 1'b1;
        chardata      = '0;
        isstring      = 1'b0;
        ispattern     = 1'b0;
        lfsr          = 16'd62500;
        pattern_count = 0;

        fd = $fopen("testbench/sme_patterns.txt", "r");
        if (fd == 0)
            stop_on_error("could not open testbench/sme_patterns.txt");

        repeat (4) @(posedge clk);
        reset <= 1'b0;

        code = $fscanf(fd, "%s", tag);
        while (code == 1)
        begin
            if (tag == "#")
            begin
                code = $fgets(rest, fd);
            end
            else if (tag == "S")
            begin
                code = $fscanf(fd, "%d %h", len, data);
                if (code != 2)
                    stop_on_error("malformed string record in pattern file");
                send_chars(len, data, 1'b0);
                idle_gap();
            end
            else if (tag == "P")
            begin
                code = $fscanf(fd, "%d %h %s %d %d", len, data, name_raw, exp_match, exp_index);
                if (code != 5)
                    stop_on_error("malformed pattern record in pattern file");
                test_name = text_of(name_raw);
                send_chars(len, data, 1'b1);
                wait_for_valid(test_name);
                check_result(test_name, "at valid", exp_match, exp_index);
                // result must hold after the pulse
                @(negedge clk);
                check_result(test_name, "held", exp_match, exp_index);
                pattern_count++;
                idle_gap();
            end
            else
            begin
                stop_on_error("unknown record type in pattern file");
            end
            code = $fscanf(fd, "%s", tag);
        end
        $fclose(fd);

        if (pattern_count > 0)
        begin
            $display("** PASS **");
            $finish;
        end
        else
        begin
            $display("no pattern records were read");
            $display("** FAIL **");
            $fatal(1, "empty pattern file");
        end
    end

endmodule

`default_nettype wire
